// ==== list.f ====
src/play_pkg.sv
src/play_bus_if.sv
src/play_sequencer.sv
src/chart_store.sv
src/score_judge.sv
src/note_display.sv
src/play_top.sv
verif/play_assert.sv
verif/tb_play_top.sv

// ==== src/chart_store.sv ====
`timescale 1ns/10ps

module chart_store
    import play_pkg::*;
(
    input  logic               prog_clk,
    input  logic               rst,
    input  logic               load_en,
    input  logic [INDEX_W-1:0] load_addr,
    input  note_t              load_note,
    play_bus_if.store          bus
);

    note_t notes [CHART_LEN];

    // Writes beyond the chart are dropped
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CHART_LEN; i++) begin
                notes[i] <= NOTE_REST;
            end
        end else if (load_en && (load_addr < INDEX_W'(CHART_LEN))) begin
            notes[load_addr[ADDR_W-1:0]] <= load_note;
        end
    end

    // Indexed read gives a rest past the end of the store
    always_comb begin
        if (bus.note_index < INDEX_W'(CHART_LEN)) begin
            bus.chart_note = notes[bus.note_index[ADDR_W-1:0]];
        end else begin
            bus.chart_note = NOTE_REST;
        end
    end

endmodule

// ==== src/note_display.sv ====
`timescale 1ns/10ps

module note_display
    import play_pkg::*;
(
    input  logic       prog_clk,
    input  logic       rst,
    output SEG_T       seg_text,
    output logic [7:0] led,
    play_bus_if.disp   bus
);

    logic [1:0] oct;
    logic [6:0] key;
    logic [2:0] key_idx;
    logic       note_valid;
    SEG_T       seg_next;
    logic [7:0] led_next;

    assign oct = bus.chart_note[8:7];
    assign key = bus.chart_note[6:0];

    // A rest has no key bit and fails the one-hot test
    assign note_valid = $onehot(key) && (oct != 2'b11);

    // Position of the set key bit
    always_comb begin
        key_idx = '0;
        for (int i = 0; i < 7; i++) begin
            if (key[i]) begin
                key_idx = 3'(i);
            end
        end
    end

    always_comb begin
        seg_next = SEG_BLANK;
        led_next = '0;
        if (note_valid) begin
            seg_next[0] = KEY_LETTERS[key_idx];
            seg_next[4] = CHAR_ONE + 8'(key_idx);
            case (oct)
                OCT_UP:   seg_next[2] = CHAR_UP;
                OCT_DOWN: seg_next[2] = CHAR_DOWN;
                default:  seg_next[2] = CHAR_SPACE;
            endcase
            // C on led[7] down to B on led[1]
            for (int i = 0; i < 7; i++) begin
                led_next[7 - i] = key[i];
            end
            led_next[0] = (oct != OCT_NONE);
        end
    end

    // Hold the last note once play stops
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            seg_text <= SEG_BLANK;
            led      <= '0;
        end else if (bus.playing && !bus.finished) begin
            seg_text <= seg_next;
            led      <= led_next;
        end
    end

endmodule

// ==== src/play_bus_if.sv ====
`timescale 1ns/10ps

// Play status and current chart note shared by the play blocks
interface play_bus_if
    import play_pkg::*;
();

    logic                playing;
    logic                finished;
    logic [INDEX_W-1:0]  note_index;
    note_t               chart_note;
    // Single-cycle strobe twice per step
    logic                scan_tick;

    modport seq (
        output playing, finished, note_index, scan_tick
    );

    modport store (
        input  note_index,
        output chart_note
    );

    modport judge (
        input playing, finished, scan_tick, chart_note
    );

    modport disp (
        input playing, finished, chart_note
    );

endinterface

// ==== src/play_pkg.sv ====
package play_pkg;

    // Octave shift in 8:7 and one-hot key C..B in 6:0
    typedef logic [8:0] note_t;

    localparam note_t NOTE_REST = '0;

    localparam logic [1:0] OCT_NONE = 2'b00;
    localparam logic [1:0] OCT_UP   = 2'b01;
    localparam logic [1:0] OCT_DOWN = 2'b10;

    // Chart size and index widths
    localparam int CHART_LEN = 32;
    localparam int INDEX_W   = 6;
    localparam int ADDR_W    = $clog2(CHART_LEN);

    localparam int SCORE_W = 14;

    // Step and scan timing in prog_clk cycles
    localparam int STEP_CYCLES = 8;
    localparam int SCAN_CYCLES = 4;
    localparam int CYCLE_W     = $clog2(STEP_CYCLES);
    localparam int COUNT_STEPS = 4;
    localparam int COUNT_W     = $clog2(COUNT_STEPS);

    // Score increments per scan
    localparam logic [SCORE_W-1:0] HIT_FULL  = 4;
    localparam logic [SCORE_W-1:0] HIT_LATE  = 2;
    localparam logic [SCORE_W-1:0] HIT_LATER = 1;

    // Segment text with character 0 leftmost
    typedef logic [0:7][7:0] SEG_T;

    localparam SEG_T SEG_BLANK = "        ";

    localparam logic [0:6][7:0] KEY_LETTERS = "cdefgab";
    localparam logic [7:0] CHAR_SPACE = " ";
    localparam logic [7:0] CHAR_UP    = "u";
    localparam logic [7:0] CHAR_DOWN  = "d";
    localparam logic [7:0] CHAR_ONE   = "1";

endpackage

// ==== src/play_sequencer.sv ====
`timescale 1ns/10ps

module play_sequencer
    import play_pkg::*;
(
    input  logic               prog_clk,
    input  logic               rst,
    input  logic [INDEX_W-1:0] chart_len,
    output logic [1:0]         count_digit,
    play_bus_if.seq            bus
);

    logic [CYCLE_W-1:0] cycle_cnt;
    logic [COUNT_W-1:0] digit_steps;
    logic [INDEX_W-1:0] next_index;
    logic               step_tick;
    logic               active;

    // Free-running cycle counter that wraps once per step
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    assign step_tick = (cycle_cnt == CYCLE_W'(STEP_CYCLES - 1));

    // Halfway tick plus the step tick itself
    assign bus.scan_tick = step_tick || (cycle_cnt == CYCLE_W'(SCAN_CYCLES - 1));

    // Countdown 3,2,1,0 then start play
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            count_digit <= 2'd3;
            digit_steps <= '0;
            bus.playing <= 1'b0;
        end else if (step_tick && !bus.playing) begin
            if (digit_steps == COUNT_W'(COUNT_STEPS - 1)) begin
                digit_steps <= '0;
                if (count_digit == 2'd0) begin
                    bus.playing <= 1'b1;
                end else begin
                    count_digit <= count_digit - 1'b1;
                end
            end else begin
                digit_steps <= digit_steps + 1'b1;
            end
        end
    end

    assign active     = bus.playing && !bus.finished;
    assign next_index = bus.note_index + 1'b1;

    // Advance through the chart and stop for good at chart_len
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            bus.note_index <= '0;
            bus.finished   <= 1'b0;
        end else if (step_tick && active) begin
            bus.note_index <= next_index;
            if (next_index == chart_len) begin
                bus.finished <= 1'b1;
            end
        end
    end

endmodule

// ==== src/play_top.sv ====
`timescale 1ns/10ps

module play_top
    import play_pkg::*;
(
    input  logic               prog_clk,
    input  logic               rst,
    input  logic               load_en,
    input  logic [INDEX_W-1:0] load_addr,
    input  note_t              load_note,
    input  logic [INDEX_W-1:0] chart_len,
    input  logic               auto_play,
    input  note_t              user_note,
    output logic [1:0]         count_digit,
    output logic               playing,
    output logic               finished,
    output logic [INDEX_W-1:0] note_index,
    output logic [SCORE_W-1:0] score,
    output SEG_T               seg_text,
    output logic [7:0]         led
);

    play_bus_if bus ();

    play_sequencer u_sequencer (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .chart_len   (chart_len),
        .count_digit (count_digit),
        .bus         (bus.seq)
    );

    chart_store u_store (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_note (load_note),
        .bus       (bus.store)
    );

    score_judge u_judge (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .auto_play (auto_play),
        .user_note (user_note),
        .score     (score),
        .bus       (bus.judge)
    );

    note_display u_display (
        .prog_clk (prog_clk),
        .rst      (rst),
        .seg_text (seg_text),
        .led      (led),
        .bus      (bus.disp)
    );

    // Play status also leaves the chip
    assign playing    = bus.playing;
    assign finished   = bus.finished;
    assign note_index = bus.note_index;

endmodule

// ==== src/score_judge.sv ====
`timescale 1ns/10ps

module score_judge
    import play_pkg::*;
(
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                auto_play,
    input  note_t               user_note,
    output logic [SCORE_W-1:0]  score,
    play_bus_if.judge           bus
);

    // Sample history with entry 0 the most recent
    note_t              history [3];
    logic [SCORE_W-1:0] hit;
    logic               judge_en;

    assign judge_en = bus.scan_tick && bus.playing && !bus.finished;

    // Earlier matches count less
    always_comb begin
        if (auto_play) begin
            hit = HIT_FULL;
        end else if ((bus.chart_note == user_note) || (bus.chart_note == history[0])) begin
            hit = HIT_FULL;
        end else if (bus.chart_note == history[1]) begin
            hit = HIT_LATE;
        end else if (bus.chart_note == history[2]) begin
            hit = HIT_LATER;
        end else begin
            hit = '0;
        end
    end

    // Score wraps on overflow
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else if (judge_en) begin
            score <= score + hit;
        end
    end

    // Only manual scans shift the history
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            history[0] <= NOTE_REST;
            history[1] <= NOTE_REST;
            history[2] <= NOTE_REST;
        end else if (judge_en && !auto_play) begin
            history[0] <= user_note;
            history[1] <= history[0];
            history[2] <= history[1];
        end
    end

endmodule

// ==== verif/play_assert.sv ====
`timescale 1ns/10ps

// Concurrent checks on play status, LEDs and score
module play_assert
    import play_pkg::*;
(
    input logic               prog_clk,
    input logic               rst,
    input logic               playing,
    input logic               finished,
    input logic [7:0]         led,
    input logic [SCORE_W-1:0] score
);

    int assertion_errors = 0;

    // Play runs until the next reset
    playing_holds: assert property (@(posedge prog_clk) disable iff (rst) playing |=> playing)
        else begin
            assertion_errors++;
            $error("playing fell without reset");
        end

    finished_in_play: assert property (@(posedge prog_clk) disable iff (rst) finished |-> playing)
        else begin
            assertion_errors++;
            $error("finished is high while playing is low");
        end

    // At most one key LED lit
    led_key_one_hot: assert property (@(posedge prog_clk) disable iff (rst) $onehot0(led[7:1]))
        else begin
            assertion_errors++;
            $error("more than one key LED is lit");
        end

    // Only a wrap may bring the score down
    score_rises: assert property (@(posedge prog_clk) disable iff (rst)
        (score >= $past(score)) || ($past(score) > ({SCORE_W{1'b1}} - HIT_FULL)))
        else begin
            assertion_errors++;
            $error("score decreased without wrapping");
        end

endmodule

bind play_top play_assert u_play_assert (
    .prog_clk (prog_clk),
    .rst      (rst),
    .playing  (playing),
    .finished (finished),
    .led      (led),
    .score    (score)
);

// ==== verif/tb_play_top.sv ====
`timescale 1ns/10ps

module tb_play_top
    import play_pkg::*;
();

    logic               prog_clk;
    logic               rst;
    logic               load_en;
    logic [INDEX_W-1:0] load_addr;
    note_t              load_note;
    logic [INDEX_W-1:0] chart_len;
    logic               auto_play;
    note_t              user_note;
    logic [1:0]         count_digit;
    logic               playing;
    logic               finished;
    logic [INDEX_W-1:0] note_index;
    logic [SCORE_W-1:0] score;
    SEG_T               seg_text;
    logic [7:0]         led;

    integer seed;
    note_t  chart [CHART_LEN];
    note_t  user_seq [CHART_LEN];

    // Display compare state
    logic               compare_due = 1'b0;
    logic               seen_active = 1'b0;
    logic [INDEX_W-1:0] due_index;
    logic [INDEX_W-1:0] seen_index;
    logic [71:0]        want_display;

    play_top DUT (.*);

    initial begin
        prog_clk = 1'b0;
        forever #5 prog_clk = ~prog_clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // 21 valid notes from 7 keys in each of 3 octave fields
    function automatic note_t note_from_index(input int idx);
        note_t n;
        n = NOTE_REST;
        n[idx % 7] = 1'b1;
        n[8:7] = 2'(idx / 7);
        return n;
    endfunction

    function automatic note_t pick_note(input note_t avoid);
        int    idx;
        note_t n;
        idx = $unsigned($random(seed)) % 21;
        n = note_from_index(idx);
        if (n == avoid) begin
            n = note_from_index((idx + 1) % 21);
        end
        return n;
    endfunction

    // Six-step key pattern hits full, late and later matches
    task automatic make_chart();
        int i;
        chart[0] = pick_note(NOTE_REST);
        for (i = 1; i < CHART_LEN; i++) begin
            chart[i] = pick_note(chart[i - 1]);
        end
        for (i = 0; i < CHART_LEN; i++) begin
            case (i % 6)
                0: user_seq[i] = chart[i];
                1: user_seq[i] = (i + 1 < CHART_LEN) ? chart[i + 1] : NOTE_REST;
                3: user_seq[i] = (i + 2 < CHART_LEN) ? chart[i + 2] : NOTE_REST;
                4: user_seq[i] = NOTE_REST;
                default: user_seq[i] = pick_note(chart[i]);
            endcase
        end
    endtask

    // Two scans per step against a three-sample history
    function automatic logic [SCORE_W-1:0] expected_score(input int len, input bit auto);
        note_t              h0;
        note_t              h1;
        note_t              h2;
        logic [SCORE_W-1:0] total;
        int                 i;
        int                 scan;
        h0 = NOTE_REST;
        h1 = NOTE_REST;
        h2 = NOTE_REST;
        total = '0;
        for (i = 0; i < len; i++) begin
            for (scan = 0; scan < 2; scan++) begin
                if (auto) begin
                    total = total + HIT_FULL;
                end else begin
                    if (chart[i] == user_seq[i] || chart[i] == h0) begin
                        total = total + HIT_FULL;
                    end else if (chart[i] == h1) begin
                        total = total + HIT_LATE;
                    end else if (chart[i] == h2) begin
                        total = total + HIT_LATER;
                    end
                    h2 = h1;
                    h1 = h0;
                    h0 = user_seq[i];
                end
            end
        end
        return total;
    endfunction

    // Segment text in 71:8 and LEDs in 7:0
    function automatic logic [71:0] expected_display(input note_t n);
        SEG_T       seg;
        logic [7:0] leds;
        string      letters;
        int         ones;
        int         k;
        int         i;
        letters = "cdefgab";
        seg = SEG_BLANK;
        leds = '0;
        ones = 0;
        k = 0;
        for (i = 0; i < 7; i++) begin
            if (n[i]) begin
                ones++;
                k = i;
            end
        end
        if (ones == 1 && n[8:7] != 2'b11) begin
            seg[0] = letters[k];
            seg[2] = (n[8:7] == 2'b01) ? "u" : ((n[8:7] == 2'b10) ? "d" : " ");
            seg[4] = 8'(49 + k);  // ASCII digit 1 is 49
            leds[7 - k] = 1'b1;
            leds[0] = (n[8:7] != 2'b00);
        end
        return {seg, leds};
    endfunction

    task automatic load_chart(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            @(posedge prog_clk);
            load_en   <= 1'b1;
            load_addr <= INDEX_W'(i);
            load_note <= chart[i];
        end
        @(posedge prog_clk);
        load_en <= 1'b0;
    endtask

    task automatic check_countdown(input string game);
        int digit;
        int cycles;
        for (digit = 3; digit >= 0; digit--) begin
            check_value({game, " countdown digit"}, digit, count_digit);
            cycles = 0;
            while (count_digit == digit && !playing) begin
                if (cycles > 2 * COUNT_STEPS * STEP_CYCLES) begin
                    fail_run("error: countdown digit did not change in time");
                end else begin
                    cycles++;
                    @(negedge prog_clk);
                end
            end
            check_value({game, " countdown length"}, COUNT_STEPS * STEP_CYCLES, cycles);
        end
    endtask

    task automatic play_game(input bit auto, input int len, input string game);
        int                 cycles;
        int                 last;
        logic [29:0]        end_state;
        SEG_T               end_text;
        make_chart();
        @(posedge prog_clk);
        rst       <= 1'b1;
        auto_play <= auto;
        chart_len <= INDEX_W'(len);
        user_note <= NOTE_REST;
        repeat (3) @(posedge prog_clk);
        rst <= 1'b0;
        @(negedge prog_clk);
        check_value({game, " reset state"}, 0, {playing, finished, score, note_index, led});
        check_value({game, " reset text"}, SEG_BLANK, seg_text);
        fork
            load_chart(len);
            check_countdown(game);
        join
        check_value({game, " play start"}, {1'b1, INDEX_W'(0)}, {playing, note_index});
        last = 0;
        @(posedge prog_clk);
        user_note <= user_seq[0];
        cycles = 0;
        // New key one cycle after each index change
        while (!finished) begin
            @(negedge prog_clk);
            cycles++;
            if (cycles > (len + 2) * STEP_CYCLES) begin
                fail_run("error: finished did not rise at the end of the chart");
            end else if (!finished && note_index != last) begin
                last = note_index;
                @(posedge prog_clk);
                user_note <= user_seq[last];
            end
        end
        check_value({game, " final index"}, len, note_index);
        check_value({game, " score"}, expected_score(len, auto), score);
        if (auto) begin
            check_value({game, " full score"}, HIT_FULL * 2 * len, score);
        end
        end_state = {finished, score, note_index, led};
        end_text = seg_text;
        repeat (3 * STEP_CYCLES) @(negedge prog_clk);
        check_value({game, " held state"}, end_state, {finished, score, note_index, led});
        check_value({game, " held text"}, end_text, seg_text);
    endtask

    // Compare the display one cycle after each index change
    always @(negedge prog_clk) begin
        if (DUT.u_play_assert.assertion_errors != 0) begin
            fail_run("error: an assertion in play_assert failed");
        end else begin
            if (compare_due) begin
                want_display = expected_display(chart[due_index]);
                check_value("display text", want_display[71:8], seg_text);
                check_value("display led", want_display[7:0], led);
            end
            compare_due = !rst && playing && !finished
                          && (!seen_active || note_index != seen_index);
            due_index = note_index;
            seen_active = !rst && playing && !finished;
            seen_index = note_index;
        end
    end

    initial begin
        seed = 33;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_note = NOTE_REST;
        chart_len = '0;
        auto_play = 1'b0;
        user_note = NOTE_REST;
        play_game(1'b1, 20, "auto");
        play_game(1'b0, 31, "manual");
        if (DUT.u_play_assert.assertion_errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("error: an assertion in play_assert failed");
        end
    end

endmodule
